/* logic/status_pkg.sv */
package status_pkg;

    // bus field widths
    typedef logic [3:0]  axi_id_t;
    typedef logic [31:0] axi_addr_t;    // byte address or word index
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;
    typedef logic [7:0]  axi_len_t;     // beats minus one
    typedef logic [1:0]  axi_burst_t;
    typedef logic [1:0]  axi_resp_t;

    // configuration fields
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] port_mask_t;   // one flag per bus port
    typedef logic [7:0]  power_mask_t;  // one flag per power port

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_RESP
    } wr_state_t;

    typedef enum logic {
        RD_IDLE,
        RD_DATA
    } rd_state_t;

    // word indices of the register map
    localparam axi_addr_t REG_BUS_STATUS   = 32'h0000_0000;
    localparam axi_addr_t REG_BUS_RESET    = 32'h0000_0001;
    localparam axi_addr_t REG_UID_HIGH     = 32'h0000_0002;
    localparam axi_addr_t REG_UID_MID      = 32'h0000_0003;
    localparam axi_addr_t REG_UID_LOW      = 32'h0000_0004;
    localparam axi_addr_t REG_POWER_STATUS = 32'h0000_0005;
    localparam axi_addr_t REG_POWER_RESET  = 32'h0000_0006;
    localparam axi_addr_t REG_MAC_HIGH     = 32'h0000_0007;
    localparam axi_addr_t REG_MAC_LOW      = 32'h0000_0008;
    localparam axi_addr_t REG_IP           = 32'h0000_0009;
    localparam axi_addr_t REG_HOST_IP      = 32'h0000_000A;  // last mapped word

    localparam axi_burst_t BURST_FIXED = 2'd0;
    localparam axi_burst_t BURST_INCR  = 2'd1;

    localparam axi_resp_t RESP_OKAY   = 2'd0;
    localparam axi_resp_t RESP_SLVERR = 2'd2;

    localparam axi_data_t UNMAPPED_DATA = 32'hFFFF_FFFF;

endpackage

/* logic/status_wr_channel.sv */
`timescale 1ns/100ps

module status_wr_channel
    import status_pkg::*;
#(
    parameter axi_addr_t base_addr = 32'h3000_0000
) (
    input  logic       clk,
    input  logic       STATUS_SLAVE_RSTN_SYNC,
    input  axi_id_t    wr_addr_id,
    input  axi_addr_t  wr_addr,
    input  axi_burst_t wr_addr_burst,
    input  logic       wr_addr_valid,
    output logic       wr_addr_ready,
    input  axi_data_t  wr_data,
    input  axi_strb_t  wr_strb,
    input  logic       wr_data_last,
    input  logic       wr_data_valid,
    output logic       wr_data_ready,
    output axi_id_t    wr_back_id,
    output axi_resp_t  wr_back_resp,
    output logic       wr_back_valid,
    input  logic       wr_back_ready,
    output logic       reg_wr_en,
    output axi_addr_t  reg_wr_index,
    output axi_data_t  reg_wr_data,
    output axi_strb_t  reg_wr_strb,
    input  logic       reg_wr_err
);

    wr_state_t  state;
    axi_id_t    id_q;
    axi_burst_t burst_q;
    axi_addr_t  index_q;
    logic       err_q;      // any beat of this burst failed
    logic       burst_bad;

    assign wr_addr_ready = (state == WR_IDLE);
    assign wr_data_ready = (state == WR_DATA);  // registers never stall
    assign wr_back_valid = (state == WR_RESP);
    assign wr_back_id    = id_q;
    assign wr_back_resp  = err_q ? RESP_SLVERR : RESP_OKAY;

    assign burst_bad = (burst_q != BURST_FIXED) && (burst_q != BURST_INCR);

    // one strobe per accepted beat
    assign reg_wr_en    = wr_data_valid && wr_data_ready;
    assign reg_wr_index = index_q;
    assign reg_wr_data  = wr_data;
    assign reg_wr_strb  = wr_strb;

    always_ff @(posedge clk or negedge STATUS_SLAVE_RSTN_SYNC) begin
        if (!STATUS_SLAVE_RSTN_SYNC) begin
            state <= WR_IDLE;
        end else begin
            case (state)
                WR_IDLE: if (wr_addr_valid) state <= WR_DATA;
                WR_DATA: if (reg_wr_en && wr_data_last) state <= WR_RESP;
                WR_RESP: if (wr_back_ready) state <= WR_IDLE;
                default: state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge STATUS_SLAVE_RSTN_SYNC) begin
        if (!STATUS_SLAVE_RSTN_SYNC) begin
            err_q <= 1'b0;
        end else if (state == WR_IDLE) begin
            err_q <= 1'b0;
        end else if (reg_wr_en && (reg_wr_err || burst_bad)) begin
            err_q <= 1'b1;                          // held until the response is taken
        end
    end

    // burst parameters and the running word index
    always_ff @(posedge clk) begin
        if (wr_addr_valid && wr_addr_ready) begin
            id_q    <= wr_addr_id;
            burst_q <= wr_addr_burst;
            index_q <= wr_addr - base_addr;         // bus address to word index
        end else if (reg_wr_en && (burst_q == BURST_INCR)) begin
            index_q <= index_q + 1'b1;
        end
    end

endmodule

/* logic/status_rd_channel.sv */
`timescale 1ns/100ps

module status_rd_channel
    import status_pkg::*;
#(
    parameter axi_addr_t base_addr = 32'h3000_0000
) (
    input  logic       clk,
    input  logic       STATUS_SLAVE_RSTN_SYNC,
    input  axi_id_t    rd_addr_id,
    input  axi_addr_t  rd_addr,
    input  axi_len_t   rd_addr_len,
    input  axi_burst_t rd_addr_burst,
    input  logic       rd_addr_valid,
    output logic       rd_addr_ready,
    output axi_id_t    rd_back_id,
    output axi_data_t  rd_data,
    output axi_resp_t  rd_data_resp,
    output logic       rd_data_last,
    output logic       rd_data_valid,
    input  logic       rd_data_ready,
    output axi_addr_t  reg_rd_index,
    input  axi_data_t  reg_rd_data,
    input  logic       reg_rd_err
);

    rd_state_t  state;
    axi_id_t    id_q;
    axi_len_t   len_q;
    axi_burst_t burst_q;
    axi_addr_t  index_q;
    axi_len_t   beat_cnt;   // beats already handed over
    logic       err_q;      // an earlier beat failed
    logic       burst_bad;
    logic       beat_err;
    logic       rd_hs;

    assign rd_addr_ready = (state == RD_IDLE);
    assign rd_data_valid = (state == RD_DATA);
    assign rd_back_id    = id_q;
    assign rd_hs         = rd_data_valid && rd_data_ready;

    assign burst_bad = (burst_q != BURST_FIXED) && (burst_q != BURST_INCR);
    assign beat_err  = reg_rd_err || burst_bad;

    // data, resp and last follow the index so they hold under back-pressure
    assign reg_rd_index = index_q;
    assign rd_data      = rd_data_valid ? reg_rd_data : '0;
    assign rd_data_last = rd_data_valid && (beat_cnt == len_q);
    assign rd_data_resp = (rd_data_valid && (err_q || beat_err)) ? RESP_SLVERR : RESP_OKAY;

    always_ff @(posedge clk or negedge STATUS_SLAVE_RSTN_SYNC) begin
        if (!STATUS_SLAVE_RSTN_SYNC) begin
            state <= RD_IDLE;
        end else begin
            case (state)
                RD_IDLE: if (rd_addr_valid) state <= RD_DATA;
                RD_DATA: if (rd_hs && rd_data_last) state <= RD_IDLE;
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge STATUS_SLAVE_RSTN_SYNC) begin
        if (!STATUS_SLAVE_RSTN_SYNC) begin
            err_q <= 1'b0;
        end else if (rd_addr_valid && rd_addr_ready) begin
            err_q <= 1'b0;                          // fresh burst
        end else if (rd_hs && beat_err) begin
            err_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_addr_valid && rd_addr_ready) begin
            id_q     <= rd_addr_id;
            len_q    <= rd_addr_len;
            burst_q  <= rd_addr_burst;
            index_q  <= rd_addr - base_addr;
            beat_cnt <= '0;
        end else if (rd_hs) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (burst_q == BURST_INCR) begin
                index_q <= index_q + 1'b1;          // fixed bursts reread one word
            end
        end
    end

endmodule

/* logic/status_regs.sv */
`timescale 1ns/100ps

module status_regs
    import status_pkg::*;
(
    input  logic        clk,
    input  logic        STATUS_SLAVE_RSTN_SYNC,
    input  logic        reg_wr_en,
    input  axi_addr_t   reg_wr_index,
    input  axi_data_t   reg_wr_data,
    input  axi_strb_t   reg_wr_strb,
    output logic        reg_wr_err,
    input  axi_addr_t   reg_rd_index,
    output axi_data_t   reg_rd_data,
    output logic        reg_rd_err,
    input  port_mask_t  axi_master_rstn_status,
    input  port_mask_t  axi_slave_rstn_status,
    output port_mask_t  axi_master_reset,
    output port_mask_t  axi_slave_reset,
    input  axi_data_t   uid_high,
    input  axi_data_t   uid_middle,
    input  axi_data_t   uid_low,
    output power_mask_t power_status,
    output power_mask_t power_reset,
    input  mac_addr_t   default_mac_addr,
    input  ip_addr_t    default_ip_addr,
    input  ip_addr_t    default_host_ip_addr,
    output mac_addr_t   mac_addr,
    output ip_addr_t    ip_addr,
    output ip_addr_t    host_ip_addr
);

    axi_data_t wr_mask;     // byte lanes enabled by the strobe
    axi_data_t wr_bits;     // written data with unstrobed lanes cleared
    logic      wr_ok;

    assign wr_mask = {{8{reg_wr_strb[3]}}, {8{reg_wr_strb[2]}},
                      {8{reg_wr_strb[1]}}, {8{reg_wr_strb[0]}}};
    assign wr_bits = reg_wr_data & wr_mask;

    // status and UID words are read only
    assign reg_wr_err = (reg_wr_index > REG_HOST_IP) ||
                        (reg_wr_index inside {REG_UID_HIGH, REG_UID_MID, REG_UID_LOW});
    // pulse words are write only
    assign reg_rd_err = (reg_rd_index > REG_HOST_IP) ||
                        (reg_rd_index inside {REG_BUS_RESET, REG_POWER_RESET});

    assign wr_ok = reg_wr_en && !reg_wr_err;

    always_ff @(posedge clk or negedge STATUS_SLAVE_RSTN_SYNC) begin
        if (!STATUS_SLAVE_RSTN_SYNC) begin
            axi_master_reset <= '0;
            axi_slave_reset  <= '0;
            power_reset      <= '0;
            power_status     <= '0;
            mac_addr         <= default_mac_addr;
            ip_addr          <= default_ip_addr;
            host_ip_addr     <= default_host_ip_addr;
        end else begin
            axi_master_reset <= '0;                 // pulses last one cycle
            axi_slave_reset  <= '0;
            power_reset      <= '0;
            if (wr_ok) begin
                case (reg_wr_index)
                    REG_BUS_RESET: begin
                        axi_master_reset <= wr_bits[31:16];
                        axi_slave_reset  <= wr_bits[15:0];
                    end
                    REG_POWER_STATUS: begin
                        power_status <= (power_status & ~wr_mask[7:0]) | wr_bits[7:0];
                    end
                    REG_POWER_RESET: begin
                        power_reset <= wr_bits[7:0];
                    end
                    REG_MAC_HIGH: begin
                        mac_addr[47:32] <= (mac_addr[47:32] & ~wr_mask[15:0]) | wr_bits[15:0];
                    end
                    REG_MAC_LOW: begin
                        mac_addr[31:0] <= (mac_addr[31:0] & ~wr_mask) | wr_bits;
                    end
                    REG_IP: begin
                        ip_addr <= (ip_addr & ~wr_mask) | wr_bits;
                    end
                    REG_HOST_IP: begin
                        host_ip_addr <= (host_ip_addr & ~wr_mask) | wr_bits;
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (reg_rd_index)
            REG_BUS_STATUS:   reg_rd_data = {axi_master_rstn_status, axi_slave_rstn_status};
            REG_UID_HIGH:     reg_rd_data = uid_high;
            REG_UID_MID:      reg_rd_data = uid_middle;
            REG_UID_LOW:      reg_rd_data = uid_low;
            REG_POWER_STATUS: reg_rd_data = {24'h0, power_status};
            REG_MAC_HIGH:     reg_rd_data = {16'h0, mac_addr[47:32]};
            REG_MAC_LOW:      reg_rd_data = mac_addr[31:0];
            REG_IP:           reg_rd_data = ip_addr;
            REG_HOST_IP:      reg_rd_data = host_ip_addr;
            default:          reg_rd_data = UNMAPPED_DATA;   // also the write-only words
        endcase
    end

endmodule

/* logic/sys_status_slave.sv */
`timescale 1ns/100ps

module sys_status_slave
    import status_pkg::*;
#(
    parameter axi_addr_t base_addr = 32'h3000_0000
) (
    input  logic        clk,
    input  logic        STATUS_SLAVE_RSTN_SYNC,
    input  axi_id_t     wr_addr_id,
    input  axi_addr_t   wr_addr,
    input  axi_len_t    wr_addr_len,            // not needed, last ends the burst
    input  axi_burst_t  wr_addr_burst,
    input  logic        wr_addr_valid,
    output logic        wr_addr_ready,
    input  axi_data_t   wr_data,
    input  axi_strb_t   wr_strb,
    input  logic        wr_data_last,
    input  logic        wr_data_valid,
    output logic        wr_data_ready,
    output axi_id_t     wr_back_id,
    output axi_resp_t   wr_back_resp,
    output logic        wr_back_valid,
    input  logic        wr_back_ready,
    input  axi_id_t     rd_addr_id,
    input  axi_addr_t   rd_addr,
    input  axi_len_t    rd_addr_len,
    input  axi_burst_t  rd_addr_burst,
    input  logic        rd_addr_valid,
    output logic        rd_addr_ready,
    output axi_id_t     rd_back_id,
    output axi_data_t   rd_data,
    output axi_resp_t   rd_data_resp,
    output logic        rd_data_last,
    output logic        rd_data_valid,
    input  logic        rd_data_ready,
    input  port_mask_t  axi_master_rstn_status,
    input  port_mask_t  axi_slave_rstn_status,
    output port_mask_t  axi_master_reset,
    output port_mask_t  axi_slave_reset,
    input  axi_data_t   uid_high,
    input  axi_data_t   uid_middle,
    input  axi_data_t   uid_low,
    output power_mask_t power_status,
    output power_mask_t power_reset,
    input  mac_addr_t   default_mac_addr,
    input  ip_addr_t    default_ip_addr,
    input  ip_addr_t    default_host_ip_addr,
    output mac_addr_t   mac_addr,
    output ip_addr_t    ip_addr,
    output ip_addr_t    host_ip_addr
);

    logic      reg_wr_en;
    axi_addr_t reg_wr_index;
    axi_data_t reg_wr_data;
    axi_strb_t reg_wr_strb;
    logic      reg_wr_err;
    axi_addr_t reg_rd_index;
    axi_data_t reg_rd_data;
    logic      reg_rd_err;

    status_wr_channel #(
        .base_addr(base_addr)
    ) u_wr_channel (
        .clk                    (clk),
        .STATUS_SLAVE_RSTN_SYNC (STATUS_SLAVE_RSTN_SYNC),
        .wr_addr_id             (wr_addr_id),
        .wr_addr                (wr_addr),
        .wr_addr_burst          (wr_addr_burst),
        .wr_addr_valid          (wr_addr_valid),
        .wr_addr_ready          (wr_addr_ready),
        .wr_data                (wr_data),
        .wr_strb                (wr_strb),
        .wr_data_last           (wr_data_last),
        .wr_data_valid          (wr_data_valid),
        .wr_data_ready          (wr_data_ready),
        .wr_back_id             (wr_back_id),
        .wr_back_resp           (wr_back_resp),
        .wr_back_valid          (wr_back_valid),
        .wr_back_ready          (wr_back_ready),
        .reg_wr_en              (reg_wr_en),
        .reg_wr_index           (reg_wr_index),
        .reg_wr_data            (reg_wr_data),
        .reg_wr_strb            (reg_wr_strb),
        .reg_wr_err             (reg_wr_err)
    );

    status_rd_channel #(
        .base_addr(base_addr)
    ) u_rd_channel (
        .clk                    (clk),
        .STATUS_SLAVE_RSTN_SYNC (STATUS_SLAVE_RSTN_SYNC),
        .rd_addr_id             (rd_addr_id),
        .rd_addr                (rd_addr),
        .rd_addr_len            (rd_addr_len),
        .rd_addr_burst          (rd_addr_burst),
        .rd_addr_valid          (rd_addr_valid),
        .rd_addr_ready          (rd_addr_ready),
        .rd_back_id             (rd_back_id),
        .rd_data                (rd_data),
        .rd_data_resp           (rd_data_resp),
        .rd_data_last           (rd_data_last),
        .rd_data_valid          (rd_data_valid),
        .rd_data_ready          (rd_data_ready),
        .reg_rd_index           (reg_rd_index),
        .reg_rd_data            (reg_rd_data),
        .reg_rd_err             (reg_rd_err)
    );

    status_regs u_regs (
        .clk                    (clk),
        .STATUS_SLAVE_RSTN_SYNC (STATUS_SLAVE_RSTN_SYNC),
        .reg_wr_en              (reg_wr_en),
        .reg_wr_index           (reg_wr_index),
        .reg_wr_data            (reg_wr_data),
        .reg_wr_strb            (reg_wr_strb),
        .reg_wr_err             (reg_wr_err),
        .reg_rd_index           (reg_rd_index),
        .reg_rd_data            (reg_rd_data),
        .reg_rd_err             (reg_rd_err),
        .axi_master_rstn_status (axi_master_rstn_status),
        .axi_slave_rstn_status  (axi_slave_rstn_status),
        .axi_master_reset       (axi_master_reset),
        .axi_slave_reset        (axi_slave_reset),
        .uid_high               (uid_high),
        .uid_middle             (uid_middle),
        .uid_low                (uid_low),
        .power_status           (power_status),
        .power_reset            (power_reset),
        .default_mac_addr       (default_mac_addr),
        .default_ip_addr        (default_ip_addr),
        .default_host_ip_addr   (default_host_ip_addr),
        .mac_addr               (mac_addr),
        .ip_addr                (ip_addr),
        .host_ip_addr           (host_ip_addr)
    );

endmodule

/* bench/sys_status_assert.sv */
`timescale 1ns/100ps

module sys_status_assert
    import status_pkg::*;
(
    input logic      clk,
    input logic      STATUS_SLAVE_RSTN_SYNC,
    input logic      wr_addr_ready,
    input logic      wr_data_ready,
    input logic      wr_back_valid,
    input logic      wr_back_ready,
    input logic      rd_data_valid,
    input logic      rd_data_ready,
    input axi_data_t rd_data
);

    int unsigned fail_count = 0;    // failed checks so far

    wr_back_hold: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        wr_back_valid && !wr_back_ready |=> wr_back_valid)
        else begin
            $error("write response withdrawn before ready");
            fail_count++;
        end

    rd_data_hold: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        rd_data_valid && !rd_data_ready |=> rd_data_valid && $stable(rd_data))
        else begin
            $error("read data changed or withdrawn before ready");
            fail_count++;
        end

    // write FSM stays busy until the response is taken
    wr_addr_busy: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        (wr_data_ready || (wr_back_valid && !wr_back_ready)) |=> !wr_addr_ready)
        else begin
            $error("write address ready before the response was taken");
            fail_count++;
        end

endmodule

bind sys_status_slave sys_status_assert u_assert (.*);

/* bench/tb_sys_status.sv */
`timescale 1ns/100ps

module tb_sys_status
    import status_pkg::*;
;

    localparam axi_addr_t BASE_ADDR   = 32'h3000_0000;     // default base of the DUT
    localparam int        TIMEOUT     = 100;               // cycles per wait loop
    localparam mac_addr_t DEF_MAC     = 48'h02_1a_2b_3c_4d_5e;
    localparam ip_addr_t  DEF_IP      = 32'hc0a8_0164;
    localparam ip_addr_t  DEF_HOST_IP = 32'hc0a8_0101;

    logic        clk = 1'b0;
    logic        STATUS_SLAVE_RSTN_SYNC = 1'b0;
    axi_id_t     wr_addr_id = '0;
    axi_addr_t   wr_addr = '0;
    axi_len_t    wr_addr_len = '0;
    axi_burst_t  wr_addr_burst = BURST_FIXED;
    logic        wr_addr_valid = 1'b0;
    logic        wr_addr_ready;
    axi_data_t   wr_data = '0;
    axi_strb_t   wr_strb = '0;
    logic        wr_data_last = 1'b0;
    logic        wr_data_valid = 1'b0;
    logic        wr_data_ready;
    axi_id_t     wr_back_id;
    axi_resp_t   wr_back_resp;
    logic        wr_back_valid;
    logic        wr_back_ready = 1'b0;
    axi_id_t     rd_addr_id = '0;
    axi_addr_t   rd_addr = '0;
    axi_len_t    rd_addr_len = '0;
    axi_burst_t  rd_addr_burst = BURST_FIXED;
    logic        rd_addr_valid = 1'b0;
    logic        rd_addr_ready;
    axi_id_t     rd_back_id;
    axi_data_t   rd_data;
    axi_resp_t   rd_data_resp;
    logic        rd_data_last;
    logic        rd_data_valid;
    logic        rd_data_ready = 1'b0;
    port_mask_t  axi_master_rstn_status = 16'h0f3c;
    port_mask_t  axi_slave_rstn_status = 16'h81e7;
    port_mask_t  axi_master_reset;
    port_mask_t  axi_slave_reset;
    axi_data_t   uid_high = 32'h5a17_0001;
    axi_data_t   uid_middle = 32'h9e42_b7c3;
    axi_data_t   uid_low = 32'h0d6f_2a88;
    power_mask_t power_status;
    power_mask_t power_reset;
    mac_addr_t   default_mac_addr = DEF_MAC;
    ip_addr_t    default_ip_addr = DEF_IP;
    ip_addr_t    default_host_ip_addr = DEF_HOST_IP;
    mac_addr_t   mac_addr;
    ip_addr_t    ip_addr;
    ip_addr_t    host_ip_addr;

    // expected register contents
    mac_addr_t   exp_mac = DEF_MAC;
    ip_addr_t    exp_ip = DEF_IP;
    ip_addr_t    exp_host = DEF_HOST_IP;
    power_mask_t exp_power = '0;
    axi_data_t   exp_data [0:15];
    axi_resp_t   exp_resp [0:15];
    logic [39:0] pulse_first;       // master, slave, power one cycle after the beat
    logic [39:0] pulse_second;
    logic [31:0] lfsr = 32'hac0d_07b0;

    sys_status_slave u_sys_status_slave (.*);

    always #20 clk = ~clk;

    task automatic end_with_failure();
        $display("TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
        end_with_failure();
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        end_with_failure();
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (expected === actual) else report_mismatch(name, expected, actual);
    endtask

    // bound handshake checks
    always @(negedge clk) begin
        if (u_sys_status_slave.u_assert.fail_count != 0) begin
            $display("bus handshake assertion failed");
            end_with_failure();
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic next_random_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic axi_data_t random_word();
        axi_data_t word;
        word = '0;
        for (int i = 0; i < 32; i++) begin
            word = {word[30:0], next_random_bit()};
        end
        return word;
    endfunction

    function automatic axi_data_t apply_strobe(input axi_data_t old, input axi_data_t data,
                                               input axi_strb_t strb);
        axi_data_t result;
        result = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) result[8*b +: 8] = data[8*b +: 8];
        end
        return result;
    endfunction

    function automatic axi_data_t model_read(input axi_addr_t index);
        case (index)
            REG_BUS_STATUS:   return {axi_master_rstn_status, axi_slave_rstn_status};
            REG_UID_HIGH:     return uid_high;
            REG_UID_MID:      return uid_middle;
            REG_UID_LOW:      return uid_low;
            REG_POWER_STATUS: return {24'h0, exp_power};
            REG_MAC_HIGH:     return {16'h0, exp_mac[47:32]};
            REG_MAC_LOW:      return exp_mac[31:0];
            REG_IP:           return exp_ip;
            REG_HOST_IP:      return exp_host;
            default:          return UNMAPPED_DATA;
        endcase
    endfunction

    function automatic logic read_err(input axi_addr_t index);
        return (index > REG_HOST_IP) || (index == REG_BUS_RESET) || (index == REG_POWER_RESET);
    endfunction

    function automatic logic write_err(input axi_addr_t index);
        return (index > REG_HOST_IP) || (index >= REG_UID_HIGH && index <= REG_UID_LOW);
    endfunction

    task automatic model_write(input axi_addr_t index, input axi_data_t data,
                               input axi_strb_t strb);
        axi_data_t next;
        next = apply_strobe(model_read(index), data, strb);
        case (index)
            REG_POWER_STATUS: exp_power = next[7:0];
            REG_MAC_HIGH:     exp_mac[47:32] = next[15:0];
            REG_MAC_LOW:      exp_mac[31:0] = next;
            REG_IP:           exp_ip = next;
            REG_HOST_IP:      exp_host = next;
            default: ;                                  // pulses and read-only words
        endcase
    endtask

    task automatic check_outputs();
        check_value("mac_addr", exp_mac, mac_addr);
        check_value("ip_addr", exp_ip, ip_addr);
        check_value("host_ip_addr", exp_host, host_ip_addr);
        check_value("power_status", exp_power, power_status);
    endtask

    // single-beat write, response ready held off for back_delay cycles
    task automatic bus_write(input axi_id_t id, input axi_addr_t index, input axi_burst_t burst,
                             input axi_data_t data, input axi_strb_t strb,
                             input axi_resp_t resp, input int back_delay);
        int wait_cnt;
        @(posedge clk);
        wr_addr_id    <= id;
        wr_addr       <= BASE_ADDR + index;
        wr_addr_burst <= burst;
        wr_addr_valid <= 1'b1;
        wait_cnt = 0;
        @(negedge clk);
        while (!wr_addr_ready) begin
            wait_cnt++;
            if (wait_cnt > TIMEOUT) report_timeout("write address ready");
            @(negedge clk);
        end
        @(posedge clk);
        wr_addr_valid <= 1'b0;
        wr_data       <= data;
        wr_strb       <= strb;
        wr_data_last  <= 1'b1;
        wr_data_valid <= 1'b1;
        wait_cnt = 0;
        @(negedge clk);
        while (!wr_data_ready) begin
            wait_cnt++;
            if (wait_cnt > TIMEOUT) report_timeout("write data ready");
            @(negedge clk);
        end
        @(posedge clk);                                 // beat taken here
        wr_data_valid <= 1'b0;
        wr_data_last  <= 1'b0;
        @(negedge clk);
        pulse_first = {axi_master_reset, axi_slave_reset, power_reset};
        @(negedge clk);
        pulse_second = {axi_master_reset, axi_slave_reset, power_reset};
        check_value("wr_back_valid", 1'b1, wr_back_valid);
        repeat (back_delay) begin
            @(negedge clk);
            check_value("wr_back_valid", 1'b1, wr_back_valid);   // waits for ready
        end
        @(posedge clk);
        wr_back_ready <= 1'b1;
        wait_cnt = 0;
        @(negedge clk);
        while (!wr_back_valid) begin
            wait_cnt++;
            if (wait_cnt > TIMEOUT) report_timeout("write response valid");
            @(negedge clk);
        end
        check_value("wr_back_resp", resp, wr_back_resp);
        check_value("wr_back_id", id, wr_back_id);
        @(posedge clk);
        wr_back_ready <= 1'b0;
    endtask

    task automatic write_reg(input axi_id_t id, input axi_addr_t index, input axi_data_t data,
                             input axi_strb_t strb, input int back_delay);
        logic err;
        err = write_err(index);
        bus_write(id, index, BURST_FIXED, data, strb, err ? RESP_SLVERR : RESP_OKAY, back_delay);
        if (!err) model_write(index, data, strb);
        check_outputs();
    endtask

    // fills exp_data and exp_resp, error sticks for the rest of the burst
    task automatic expect_burst(input axi_addr_t index, input axi_len_t len,
                                input axi_burst_t burst);
        axi_addr_t idx;
        logic      err;
        idx = index;
        err = (burst != BURST_FIXED) && (burst != BURST_INCR);
        for (int i = 0; i <= len; i++) begin
            err = err || read_err(idx);
            exp_data[i] = model_read(idx);
            exp_resp[i] = err ? RESP_SLVERR : RESP_OKAY;
            if (burst == BURST_INCR) idx = idx + 1;
        end
    endtask

    task automatic bus_read(input axi_id_t id, input axi_addr_t index, input axi_len_t len,
                            input axi_burst_t burst, input logic stall);
        int wait_cnt;
        int beat;
        @(posedge clk);
        rd_addr_id    <= id;
        rd_addr       <= BASE_ADDR + index;
        rd_addr_len   <= len;
        rd_addr_burst <= burst;
        rd_addr_valid <= 1'b1;
        wait_cnt = 0;
        @(negedge clk);
        while (!rd_addr_ready) begin
            wait_cnt++;
            if (wait_cnt > TIMEOUT) report_timeout("read address ready");
            @(negedge clk);
        end
        @(posedge clk);
        rd_addr_valid <= 1'b0;
        beat = 0;
        wait_cnt = 0;
        while (beat <= len) begin
            @(posedge clk);
            if (stall) rd_data_ready <= next_random_bit();
            else rd_data_ready <= 1'b1;
            @(negedge clk);
            if (rd_data_valid && rd_data_ready) begin
                check_value("rd_data", exp_data[beat], rd_data);
                check_value("rd_data_resp", exp_resp[beat], rd_data_resp);
                check_value("rd_data_last", beat == len, rd_data_last);
                check_value("rd_back_id", id, rd_back_id);
                beat++;
                wait_cnt = 0;
            end else begin
                wait_cnt++;
                if (wait_cnt > TIMEOUT) report_timeout("read data beat");
            end
        end
        @(posedge clk);
        rd_data_ready <= 1'b0;
    endtask

    task automatic read_check(input axi_id_t id, input axi_addr_t index, input axi_len_t len,
                              input axi_burst_t burst, input logic stall);
        expect_burst(index, len, burst);
        bus_read(id, index, len, burst, stall);
    endtask

    task automatic check_after_reset();
        @(negedge clk);
        check_value("wr_addr_ready", 1'b1, wr_addr_ready);
        check_value("rd_addr_ready", 1'b1, rd_addr_ready);
        check_value("wr_data_ready", 1'b0, wr_data_ready);
        check_value("wr_back_valid", 1'b0, wr_back_valid);
        check_value("rd_data_valid", 1'b0, rd_data_valid);
        check_value("reset pulses", '0, {axi_master_reset, axi_slave_reset, power_reset});
        check_outputs();
    endtask

    task automatic write_and_read_back();
        write_reg(4'h1, REG_MAC_HIGH, 32'h1234_abcd, 4'b1111, 0);
        write_reg(4'h2, REG_MAC_LOW, 32'h5566_7788, 4'b0101, 0);
        write_reg(4'h3, REG_IP, 32'h0a0b_0c0d, 4'b1000, 0);
        write_reg(4'h4, REG_HOST_IP, 32'h0a00_0001, 4'b1111, 0);
        write_reg(4'h5, REG_POWER_STATUS, 32'hffff_ff5a, 4'b0001, 0);
        for (int i = 0; i <= REG_HOST_IP; i++) begin
            read_check(4'h6, i, 0, BURST_FIXED, 1'b0);   // whole map, one word each
        end
    endtask

    task automatic reset_pulses();
        write_reg(4'h7, REG_BUS_RESET, 32'ha5c3_3c5a, 4'b1111, 0);
        check_value("axi_master_reset", 16'ha5c3, pulse_first[39:24]);
        check_value("axi_slave_reset", 16'h3c5a, pulse_first[23:8]);
        check_value("reset pulses after one cycle", '0, pulse_second);
        write_reg(4'h8, REG_POWER_RESET, 32'h0000_0096, 4'b0001, 0);
        check_value("power_reset", 8'h96, pulse_first[7:0]);
        check_value("reset pulses after one cycle", '0, pulse_second);
    endtask

    task automatic incr_read_burst();
        read_check(4'h9, REG_BUS_STATUS, 3, BURST_INCR, 1'b0);
        read_check(4'ha, REG_UID_HIGH, 2, BURST_INCR, 1'b0);    // the three UID words
    endtask

    task automatic error_rules();
        write_reg(4'hb, REG_UID_HIGH, 32'h0000_0000, 4'b1111, 0);
        read_check(4'hc, REG_BUS_RESET, 0, BURST_FIXED, 1'b0);
        read_check(4'hd, 32'h0000_000b, 0, BURST_FIXED, 1'b0);
        bus_write(4'he, REG_BUS_STATUS, 2'd2, 32'h0000_0001, 4'b1111, RESP_SLVERR, 0);
        check_outputs();
        read_check(4'hf, REG_IP, 0, 2'd2, 1'b0);
        read_check(4'h1, REG_HOST_IP, 1, BURST_INCR, 1'b0);     // okay then past the map
    endtask

    task automatic back_pressure();
        write_reg(4'h2, REG_HOST_IP, random_word(), 4'b1111, 5);
        write_reg(4'h3, REG_IP, random_word(), 4'b0110, 3);
        read_check(4'h4, REG_MAC_HIGH, 3, BURST_INCR, 1'b1);
        read_check(4'h5, REG_IP, 2, BURST_FIXED, 1'b1);
        read_check(4'h6, REG_BUS_STATUS, 4, BURST_INCR, 1'b1);
    endtask

    initial begin
        repeat (10) @(posedge clk);
        STATUS_SLAVE_RSTN_SYNC <= 1'b1;
        check_after_reset();
        write_and_read_back();
        reset_pulses();
        incr_read_burst();
        error_rules();
        back_pressure();
        @(negedge clk);
        if (u_sys_status_slave.u_assert.fail_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("bus handshake assertion failed");
            end_with_failure();
        end
    end

endmodule

/* files.f */
logic/status_pkg.sv
logic/status_wr_channel.sv
logic/status_rd_channel.sv
logic/status_regs.sv
logic/sys_status_slave.sv
bench/sys_status_assert.sv
bench/tb_sys_status.sv

/* Bender.yml */
package:
  name: sys_status_slave

sources:
  - logic/status_pkg.sv
  - logic/status_wr_channel.sv
  - logic/status_rd_channel.sv
  - logic/status_regs.sv
  - logic/sys_status_slave.sv
  - target: test
    files:
      - bench/sys_status_assert.sv
      - bench/tb_sys_status.sv
